//--- hw/branch_resolver.sv
module branch_resolver
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  micro_op_t        i_op,
    input  logic [XLEN-1:0]  i_src0,
    input  logic [XLEN-1:0]  i_src1,
    input  logic [19:0]      i_imm20,
    input  logic [XLEN-1:0]  i_pc,
    input  logic [XLEN-1:0]  i_pred_npc,
    input  logic             i_rd_wen,
    input  logic             i_lt,
    input  logic             i_ltu,
    output logic             o_bru_owns,
    output logic [XLEN-1:0]  o_bru_result,
    output logic             o_taken,
    output logic [XLEN-1:0]  o_target,
    output logic [XLEN-1:0]  o_npc,
    output logic             o_mispred,
    output branch_type_t     o_br_type
);
    localparam logic [XLEN-1:0] FALLTHRU_STEP = XLEN'(4);

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] auipc_imm;
    logic [XLEN-1:0] fallthru;
    logic [XLEN-1:0] auipc_sum;
    logic            is_ctrl;
    logic            src_eq;

    assign imm_sext  = {{(XLEN-20){i_imm20[19]}}, i_imm20};
    assign auipc_imm = {{(XLEN-32){i_imm20[19]}}, i_imm20, 12'b0};
    assign fallthru  = i_pc + FALLTHRU_STEP;
    assign auipc_sum = i_pc + auipc_imm;
    assign src_eq    = i_src0 == i_src1;

    assign o_bru_owns = i_op >= op_auipc;
    // jumps and conditional branches, auipc excluded
    assign is_ctrl    = i_op > op_auipc;

    // auipc sum, or the link value for jal and jalr
    assign o_bru_result = (i_op == op_auipc) ? auipc_sum : fallthru;

    always_comb begin
        case (i_op)
            op_jal:  o_taken = 1'b1;
            op_jalr: o_taken = 1'b1;
            op_beq:  o_taken = src_eq;
            op_bne:  o_taken = !src_eq;
            op_blt:  o_taken = i_lt;
            op_bge:  o_taken = !i_lt;
            op_bltu: o_taken = i_ltu;
            op_bgeu: o_taken = !i_ltu;
            default: o_taken = 1'b0;
        endcase
    end

    // jalr is register relative, everything else pc relative
    assign o_target = (i_op == op_jalr) ? i_src0 + imm_sext : i_pc + imm_sext;
    assign o_npc    = o_taken ? o_target : fallthru;

    assign o_mispred = is_ctrl && (o_npc != i_pred_npc);

    always_comb begin
        if (i_op == op_jalr) begin
            o_br_type = i_rd_wen ? br_call : br_ret;
        end else if (i_op == op_jal) begin
            o_br_type = br_direct;
        end else begin
            o_br_type = br_cond;
        end
    end

endmodule

//--- hw/exec_ctrl.sv
module exec_ctrl
    import exec_pkg::*;
#(
    parameter int XLEN      = 64,
    parameter int ROB_IDX_W = 6,
    parameter int PRD_IDX_W = 7,
    parameter int FTQ_IDX_W = 4,
    parameter int FTQ_OFS_W = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_vld,
    input  micro_op_t            i_op,
    input  logic [XLEN-1:0]      i_src0,
    input  logic [XLEN-1:0]      i_src1,
    input  logic [19:0]          i_imm20,
    input  logic [XLEN-1:0]      i_pc,
    input  logic [XLEN-1:0]      i_pred_npc,
    input  logic [ROB_IDX_W-1:0] i_rob_idx,
    input  logic [PRD_IDX_W-1:0] i_prd_idx,
    input  logic                 i_rd_wen,
    input  logic [FTQ_IDX_W-1:0] i_ftq_idx,
    input  logic [FTQ_OFS_W-1:0] i_ftq_offset,
    input  logic                 i_wb_stall,
    input  logic [XLEN-1:0]      i_alu_result,
    input  logic                 i_bru_owns,
    input  logic [XLEN-1:0]      i_bru_result,
    input  logic                 i_taken,
    input  logic [XLEN-1:0]      i_target,
    input  logic [XLEN-1:0]      i_npc,
    input  logic                 i_mispred,
    input  branch_type_t         i_br_type,
    output micro_op_t            o_s1_op,
    output logic [XLEN-1:0]      o_s1_src0,
    output logic [XLEN-1:0]      o_s1_src1,
    output logic [19:0]          o_s1_imm20,
    output logic [XLEN-1:0]      o_s1_pc,
    output logic [XLEN-1:0]      o_s1_pred_npc,
    output logic                 o_s1_rd_wen,
    output logic                 o_willwrite_vld,
    output logic [PRD_IDX_W-1:0] o_willwrite_prd,
    output logic [XLEN-1:0]      o_willwrite_data,
    output logic                 o_fu_finished,
    output logic [ROB_IDX_W-1:0] o_wb_rob_idx,
    output logic [PRD_IDX_W-1:0] o_wb_prd_idx,
    output logic                 o_wb_rd_wen,
    output logic [XLEN-1:0]      o_wb_result,
    output logic                 o_brwb_vld,
    output logic [ROB_IDX_W-1:0] o_brwb_rob_idx,
    output logic [FTQ_IDX_W-1:0] o_brwb_ftq_idx,
    output branch_type_t         o_brwb_type,
    output logic                 o_brwb_taken,
    output logic [XLEN-1:0]      o_brwb_target,
    output logic [XLEN-1:0]      o_brwb_npc,
    output logic [FTQ_OFS_W-1:0] o_brwb_fallthru_ofs
);
    logic                 s1_vld;
    logic [ROB_IDX_W-1:0] s1_rob_idx;
    logic [PRD_IDX_W-1:0] s1_prd_idx;
    logic [FTQ_IDX_W-1:0] s1_ftq_idx;
    logic [FTQ_OFS_W-1:0] s1_ftq_offset;
    logic [XLEN-1:0]      s1_result;

    // valid bits of both stages, frozen by the stall
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld        <= 1'b0;
            o_fu_finished <= 1'b0;
            o_brwb_vld    <= 1'b0;
        end else if (!i_wb_stall) begin
            s1_vld        <= i_vld;
            o_fu_finished <= s1_vld;
            // only a mispredict goes back to the ftq
            o_brwb_vld    <= s1_vld && i_mispred;
        end
    end

    // stage one payload
    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            o_s1_op       <= i_op;
            o_s1_src0     <= i_src0;
            o_s1_src1     <= i_src1;
            o_s1_imm20    <= i_imm20;
            o_s1_pc       <= i_pc;
            o_s1_pred_npc <= i_pred_npc;
            o_s1_rd_wen   <= i_rd_wen;
            s1_rob_idx    <= i_rob_idx;
            s1_prd_idx    <= i_prd_idx;
            s1_ftq_idx    <= i_ftq_idx;
            s1_ftq_offset <= i_ftq_offset;
        end
    end

    assign s1_result = i_bru_owns ? i_bru_result : i_alu_result;

    // bypass to register read, one cycle after capture
    assign o_willwrite_vld  = s1_vld && o_s1_rd_wen;
    assign o_willwrite_prd  = s1_prd_idx;
    assign o_willwrite_data = s1_result;

    // stage two writeback payload
    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            o_wb_rob_idx        <= s1_rob_idx;
            o_wb_prd_idx        <= s1_prd_idx;
            o_wb_rd_wen         <= o_s1_rd_wen;
            o_wb_result         <= s1_result;
            o_brwb_rob_idx      <= s1_rob_idx;
            o_brwb_ftq_idx      <= s1_ftq_idx;
            o_brwb_type         <= i_br_type;
            o_brwb_taken        <= i_taken;
            o_brwb_target       <= i_target;
            o_brwb_npc          <= i_npc;
            o_brwb_fallthru_ofs <= s1_ftq_offset + FTQ_OFS_W'(4);
        end
    end

endmodule

//--- hw/exec_pkg.sv
package exec_pkg;

    // ops from op_auipc upward go to the branch path
    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_and   = 5'd2,
        op_or    = 5'd3,
        op_xor   = 5'd4,
        op_sll   = 5'd5,
        op_srl   = 5'd6,
        op_sra   = 5'd7,
        op_slt   = 5'd8,
        op_sltu  = 5'd9,
        op_auipc = 5'd10,
        op_jal   = 5'd11,
        op_jalr  = 5'd12,
        op_beq   = 5'd13,
        op_bne   = 5'd14,
        op_blt   = 5'd15,
        op_bge   = 5'd16,
        op_bltu  = 5'd17,
        op_bgeu  = 5'd18
    } micro_op_t;

    // branch class reported to the fetch target queue
    typedef enum logic [1:0] {
        br_cond   = 2'd0,
        br_direct = 2'd1,
        br_call   = 2'd2,
        br_ret    = 2'd3
    } branch_type_t;

endpackage

//--- hw/int_alu.sv
module int_alu
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  micro_op_t        i_op,
    input  logic [XLEN-1:0]  i_src0,
    input  logic [XLEN-1:0]  i_src1,
    output logic [XLEN-1:0]  o_alu_result,
    output logic             o_lt,
    output logic             o_ltu
);
    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;

    assign shamt = i_src1[SHAMT_W-1:0];
    assign sum   = i_src0 + i_src1;
    assign diff  = i_src0 - i_src1;

    // comparators shared with the branch path
    assign o_lt  = $signed(i_src0) < $signed(i_src1);
    assign o_ltu = i_src0 < i_src1;

    always_comb begin
        case (i_op)
            op_add: begin
                o_alu_result = sum;
            end
            op_sub: begin
                o_alu_result = diff;
            end
            op_and: begin
                o_alu_result = i_src0 & i_src1;
            end
            op_or: begin
                o_alu_result = i_src0 | i_src1;
            end
            op_xor: begin
                o_alu_result = i_src0 ^ i_src1;
            end
            op_sll: begin
                o_alu_result = i_src0 << shamt;
            end
            op_srl: begin
                o_alu_result = i_src0 >> shamt;
            end
            op_sra: begin
                o_alu_result = $unsigned($signed(i_src0) >>> shamt);
            end
            op_slt: begin
                o_alu_result = {{(XLEN-1){1'b0}}, o_lt};
            end
            op_sltu: begin
                o_alu_result = {{(XLEN-1){1'b0}}, o_ltu};
            end
            // branch ops take their result from the resolver
            default: begin
                o_alu_result = '0;
            end
        endcase
    end

endmodule

//--- hw/int_exec_unit.sv
module int_exec_unit
    import exec_pkg::*;
#(
    parameter int XLEN      = 64,
    parameter int ROB_IDX_W = 6,
    parameter int PRD_IDX_W = 7,
    parameter int FTQ_IDX_W = 4,
    parameter int FTQ_OFS_W = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_vld,
    input  micro_op_t            i_op,
    input  logic [XLEN-1:0]      i_src0,
    input  logic [XLEN-1:0]      i_src1,
    input  logic [19:0]          i_imm20,
    input  logic [XLEN-1:0]      i_pc,
    input  logic [XLEN-1:0]      i_pred_npc,
    input  logic [ROB_IDX_W-1:0] i_rob_idx,
    input  logic [PRD_IDX_W-1:0] i_prd_idx,
    input  logic                 i_rd_wen,
    input  logic [FTQ_IDX_W-1:0] i_ftq_idx,
    input  logic [FTQ_OFS_W-1:0] i_ftq_offset,
    input  logic                 i_wb_stall,
    output logic                 o_willwrite_vld,
    output logic [PRD_IDX_W-1:0] o_willwrite_prd,
    output logic [XLEN-1:0]      o_willwrite_data,
    output logic                 o_fu_finished,
    output logic [ROB_IDX_W-1:0] o_wb_rob_idx,
    output logic [PRD_IDX_W-1:0] o_wb_prd_idx,
    output logic                 o_wb_rd_wen,
    output logic [XLEN-1:0]      o_wb_result,
    output logic                 o_brwb_vld,
    output logic [ROB_IDX_W-1:0] o_brwb_rob_idx,
    output logic [FTQ_IDX_W-1:0] o_brwb_ftq_idx,
    output branch_type_t         o_brwb_type,
    output logic                 o_brwb_taken,
    output logic [XLEN-1:0]      o_brwb_target,
    output logic [XLEN-1:0]      o_brwb_npc,
    output logic [FTQ_OFS_W-1:0] o_brwb_fallthru_ofs
);
    // stage one operands
    micro_op_t       s1_op;
    logic [XLEN-1:0] s1_src0;
    logic [XLEN-1:0] s1_src1;
    logic [19:0]     s1_imm20;
    logic [XLEN-1:0] s1_pc;
    logic [XLEN-1:0] s1_pred_npc;
    logic            s1_rd_wen;

    // datapath results
    logic [XLEN-1:0] alu_result;
    logic            lt;
    logic            ltu;
    logic            bru_owns;
    logic [XLEN-1:0] bru_result;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] npc;
    logic            mispred;
    branch_type_t    br_type;

    exec_ctrl #(
        .XLEN      (XLEN),
        .ROB_IDX_W (ROB_IDX_W),
        .PRD_IDX_W (PRD_IDX_W),
        .FTQ_IDX_W (FTQ_IDX_W),
        .FTQ_OFS_W (FTQ_OFS_W)
    ) u_exec_ctrl (
        .*,
        .i_alu_result  (alu_result),
        .i_bru_owns    (bru_owns),
        .i_bru_result  (bru_result),
        .i_taken       (taken),
        .i_target      (target),
        .i_npc         (npc),
        .i_mispred     (mispred),
        .i_br_type     (br_type),
        .o_s1_op       (s1_op),
        .o_s1_src0     (s1_src0),
        .o_s1_src1     (s1_src1),
        .o_s1_imm20    (s1_imm20),
        .o_s1_pc       (s1_pc),
        .o_s1_pred_npc (s1_pred_npc),
        .o_s1_rd_wen   (s1_rd_wen)
    );

    int_alu #(
        .XLEN (XLEN)
    ) u_int_alu (
        .i_op         (s1_op),
        .i_src0       (s1_src0),
        .i_src1       (s1_src1),
        .o_alu_result (alu_result),
        .o_lt         (lt),
        .o_ltu        (ltu)
    );

    // reuses the alu comparators for the conditional branches
    branch_resolver #(
        .XLEN (XLEN)
    ) u_branch_resolver (
        .i_op         (s1_op),
        .i_src0       (s1_src0),
        .i_src1       (s1_src1),
        .i_imm20      (s1_imm20),
        .i_pc         (s1_pc),
        .i_pred_npc   (s1_pred_npc),
        .i_rd_wen     (s1_rd_wen),
        .i_lt         (lt),
        .i_ltu        (ltu),
        .o_bru_owns   (bru_owns),
        .o_bru_result (bru_result),
        .o_taken      (taken),
        .o_target     (target),
        .o_npc        (npc),
        .o_mispred    (mispred),
        .o_br_type    (br_type)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module int_exec_unit_tb \
    -f vlog.f \
    -o sim_int_exec_unit

status=0
./obj_dir/sim_int_exec_unit > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sim/int_exec_unit_checker.sv
module int_exec_unit_checker #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            rst,
    input logic            i_vld,
    input logic            i_wb_stall,
    input logic            i_fu_finished,
    input logic            i_brwb_vld,
    input logic            i_willwrite_vld,
    input logic [XLEN-1:0] i_wb_result
);
    timeunit 1ns;
    timeprecision 1ps;

    // a branch writeback always rides on a completion
    brwb_with_finish: assert property (@(posedge clk) disable iff (rst)
        i_brwb_vld |-> i_fu_finished)
        else $error("branch writeback raised without fu_finished");

    // stall freezes the writeback stage
    stall_holds_wb: assert property (@(posedge clk) disable iff (rst)
        i_wb_stall |=> ($stable(i_fu_finished) && $stable(i_wb_result)))
        else $error("writeback changed during a stalled cycle");

    // outside a stall the bypass follows the previous issue strobe
    bypass_follows_issue: assert property (@(posedge clk) disable iff (rst)
        (i_willwrite_vld && !$past(i_wb_stall)) |-> $past(i_vld))
        else $error("bypass valid without an issued op one cycle before");

endmodule

bind int_exec_unit int_exec_unit_checker #(
    .XLEN (XLEN)
) u_int_exec_unit_checker (
    .clk             (clk),
    .rst             (rst),
    .i_vld           (i_vld),
    .i_wb_stall      (i_wb_stall),
    .i_fu_finished   (o_fu_finished),
    .i_brwb_vld      (o_brwb_vld),
    .i_willwrite_vld (o_willwrite_vld),
    .i_wb_result     (o_wb_result)
);

//--- sim/int_exec_unit_tb.sv
module int_exec_unit_tb
    import exec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] FALLTHRU_STEP = 64'd4;
    localparam int WAIT_LIMIT = 20;

    logic            clk;
    logic            rst;
    logic            i_vld;
    micro_op_t       i_op;
    logic [63:0]     i_src0;
    logic [63:0]     i_src1;
    logic [19:0]     i_imm20;
    logic [63:0]     i_pc;
    logic [63:0]     i_pred_npc;
    logic [5:0]      i_rob_idx;
    logic [6:0]      i_prd_idx;
    logic            i_rd_wen;
    logic [3:0]      i_ftq_idx;
    logic [4:0]      i_ftq_offset;
    logic            i_wb_stall;
    logic            o_willwrite_vld;
    logic [6:0]      o_willwrite_prd;
    logic [63:0]     o_willwrite_data;
    logic            o_fu_finished;
    logic [5:0]      o_wb_rob_idx;
    logic [6:0]      o_wb_prd_idx;
    logic            o_wb_rd_wen;
    logic [63:0]     o_wb_result;
    logic            o_brwb_vld;
    logic [5:0]      o_brwb_rob_idx;
    logic [3:0]      o_brwb_ftq_idx;
    branch_type_t    o_brwb_type;
    logic            o_brwb_taken;
    logic [63:0]     o_brwb_target;
    logic [63:0]     o_brwb_npc;
    logic [4:0]      o_brwb_fallthru_ofs;

    int seed;
    int errors;
    int checks;

    int_exec_unit u_int_exec_unit (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // reference behavior of both paths
    function automatic void model(
        input  micro_op_t    op,
        input  logic [63:0]  src0,
        input  logic [63:0]  src1,
        input  logic [19:0]  imm20,
        input  logic [63:0]  pc,
        input  logic [63:0]  pred_npc,
        input  logic         rd_wen,
        output logic [63:0]  result,
        output logic         taken,
        output logic [63:0]  target,
        output logic [63:0]  npc,
        output logic         mispred,
        output branch_type_t br_type
    );
        logic [63:0] imm_sext;
        logic [5:0]  shamt;
        logic        ctrl;
        imm_sext = {{44{imm20[19]}}, imm20};
        shamt = src1[5:0];
        taken = 1'b0;
        ctrl = 1'b1;
        // link value unless an alu op or auipc overrides it
        result = pc + FALLTHRU_STEP;
        case (op)
            op_add:   result = src0 + src1;
            op_sub:   result = src0 - src1;
            op_and:   result = src0 & src1;
            op_or:    result = src0 | src1;
            op_xor:   result = src0 ^ src1;
            op_sll:   result = src0 << shamt;
            op_srl:   result = src0 >> shamt;
            op_sra:   result = $unsigned($signed(src0) >>> shamt);
            op_slt:   result = {63'd0, $signed(src0) < $signed(src1)};
            op_sltu:  result = {63'd0, src0 < src1};
            op_auipc: result = pc + {{32{imm20[19]}}, imm20, 12'd0};
            op_jal:   taken = 1'b1;
            op_jalr:  taken = 1'b1;
            op_beq:   taken = src0 == src1;
            op_bne:   taken = src0 != src1;
            op_blt:   taken = $signed(src0) < $signed(src1);
            op_bge:   taken = $signed(src0) >= $signed(src1);
            op_bltu:  taken = src0 < src1;
            op_bgeu:  taken = src0 >= src1;
            default:  taken = 1'b0;
        endcase
        if (op == op_add || op == op_sub || op == op_and || op == op_or || op == op_xor ||
            op == op_sll || op == op_srl || op == op_sra || op == op_slt ||
            op == op_sltu || op == op_auipc) begin
            ctrl = 1'b0;
        end
        target = (op == op_jalr) ? src0 + imm_sext : pc + imm_sext;
        npc = taken ? target : pc + FALLTHRU_STEP;
        mispred = ctrl && (npc != pred_npc);
        if (op == op_jalr) begin
            br_type = rd_wen ? br_call : br_ret;
        end else if (op == op_jal) begin
            br_type = br_direct;
        end else begin
            br_type = br_cond;
        end
    endfunction

    function automatic logic [63:0] expected_npc(input micro_op_t op, input logic [63:0] src0,
            input logic [63:0] src1, input logic [19:0] imm20, input logic [63:0] pc);
        logic [63:0]  result;
        logic [63:0]  target;
        logic [63:0]  npc;
        logic         taken;
        logic         mispred;
        branch_type_t br_type;
        model(op, src0, src1, imm20, pc, 64'd0, 1'b0, result, taken, target, npc, mispred,
              br_type);
        return npc;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_op(input micro_op_t op, input logic [63:0] src0,
            input logic [63:0] src1, input logic [19:0] imm20, input logic [63:0] pc,
            input logic [63:0] pred_npc, input logic [5:0] rob, input logic [6:0] prd,
            input logic rd_wen, input logic [3:0] ftq, input logic [4:0] ofs);
        i_vld = 1'b1;
        i_op = op;
        i_src0 = src0;
        i_src1 = src1;
        i_imm20 = imm20;
        i_pc = pc;
        i_pred_npc = pred_npc;
        i_rob_idx = rob;
        i_prd_idx = prd;
        i_rd_wen = rd_wen;
        i_ftq_idx = ftq;
        i_ftq_offset = ofs;
    endtask

    // one op through the pipe, checking bypass, latency and both writebacks
    task automatic run_op(input micro_op_t op, input logic [63:0] src0, input logic [63:0] src1,
            input logic [19:0] imm20, input logic [63:0] pc, input logic [63:0] pred_npc,
            input logic rd_wen);
        logic [63:0]  exp_result;
        logic [63:0]  exp_target;
        logic [63:0]  exp_npc;
        logic         exp_taken;
        logic         exp_mispred;
        branch_type_t exp_type;
        logic [5:0]   rob;
        logic [6:0]   prd;
        logic [3:0]   ftq;
        logic [4:0]   ofs;
        int           cycles;
        model(op, src0, src1, imm20, pc, pred_npc, rd_wen, exp_result, exp_taken, exp_target,
              exp_npc, exp_mispred, exp_type);
        rob = 6'($random(seed));
        prd = 7'($random(seed));
        ftq = 4'($random(seed));
        ofs = 5'($random(seed));
        @(posedge clk);
        #2;
        drive_op(op, src0, src1, imm20, pc, pred_npc, rob, prd, rd_wen, ftq, ofs);
        @(posedge clk);
        #2;
        i_vld = 1'b0;
        @(negedge clk);
        check_val("o_willwrite_vld", 64'(o_willwrite_vld), 64'(rd_wen));
        if (rd_wen) begin
            check_val("o_willwrite_prd", 64'(o_willwrite_prd), 64'(prd));
            check_val("o_willwrite_data", o_willwrite_data, exp_result);
        end
        cycles = 1;
        while (!o_fu_finished && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (o_fu_finished) else begin
            $display("o_fu_finished did not rise within %0d cycles for op %s", WAIT_LIMIT,
                     op.name());
            errors++;
        end
        if (o_fu_finished) begin
            check_val("latency", 64'(cycles), 64'd2);
            check_val("o_wb_result", o_wb_result, exp_result);
            check_val("o_wb_rob_idx", 64'(o_wb_rob_idx), 64'(rob));
            check_val("o_wb_prd_idx", 64'(o_wb_prd_idx), 64'(prd));
            check_val("o_wb_rd_wen", 64'(o_wb_rd_wen), 64'(rd_wen));
            check_val("o_brwb_vld", 64'(o_brwb_vld), 64'(exp_mispred));
            if (exp_mispred) begin
                check_val("o_brwb_rob_idx", 64'(o_brwb_rob_idx), 64'(rob));
                check_val("o_brwb_ftq_idx", 64'(o_brwb_ftq_idx), 64'(ftq));
                check_val("o_brwb_type", 64'(o_brwb_type), 64'(exp_type));
                check_val("o_brwb_taken", 64'(o_brwb_taken), 64'(exp_taken));
                check_val("o_brwb_target", o_brwb_target, exp_target);
                check_val("o_brwb_npc", o_brwb_npc, exp_npc);
                check_val("o_brwb_fallthru_ofs", 64'(o_brwb_fallthru_ofs),
                          64'(5'(ofs + 5'd4)));
            end
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("o_fu_finished", 64'(o_fu_finished), 64'd0);
        check_val("o_brwb_vld", 64'(o_brwb_vld), 64'd0);
        check_val("o_willwrite_vld", 64'(o_willwrite_vld), 64'd0);
    endtask

    task automatic test_alu_ops();
        micro_op_t alu_ops [10];
        alu_ops = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_slt,
                    op_sltu};
        for (int k = 0; k < 10; k++) begin
            run_op(alu_ops[k], rand_word(), rand_word(), 20'd0, rand_word(), rand_word(), 1'b1);
        end
        // negative against positive splits the two compares
        run_op(op_slt, 64'hffff_ffff_ffff_fff0, 64'd3, 20'd0, 64'h1000, 64'd0, 1'b1);
        run_op(op_sltu, 64'hffff_ffff_ffff_fff0, 64'd3, 20'd0, 64'h1000, 64'd0, 1'b1);
    endtask

    task automatic test_bypass();
        for (int k = 0; k < 4; k++) begin
            run_op(op_add, rand_word(), rand_word(), 20'd0, rand_word(), rand_word(), k[0]);
        end
    endtask

    task automatic test_cond_branches();
        micro_op_t   cond_ops [6];
        logic [63:0] sa [3];
        logic [63:0] sb [3];
        logic [63:0] pc;
        logic [63:0] npc;
        logic [19:0] imm;
        cond_ops = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        pc = rand_word() & ~64'd3;
        imm = 20'($random(seed)) & 20'hffffe;
        // small positive against negative, both orders, and equal
        sa[0] = rand_word() & 64'h7fff_ffff_ffff_ffff;
        sb[0] = rand_word() | 64'h8000_0000_0000_0000;
        sa[1] = sb[0];
        sb[1] = sa[0];
        sa[2] = sa[0];
        sb[2] = sa[0];
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < 3; s++) begin
                npc = expected_npc(cond_ops[k], sa[s], sb[s], imm, pc);
                run_op(cond_ops[k], sa[s], sb[s], imm, pc, npc, 1'b0);
                run_op(cond_ops[k], sa[s], sb[s], imm, pc, npc + 64'd8, 1'b0);
            end
        end
    endtask

    task automatic test_jumps();
        logic [63:0] pc;
        logic [63:0] base;
        logic [63:0] npc;
        logic [19:0] imm;
        pc = rand_word() & ~64'd3;
        base = rand_word();
        // negative offset keeps the target away from pc plus 4
        imm = 20'($random(seed)) | 20'h80000;
        npc = expected_npc(op_jal, 64'd0, 64'd0, imm, pc);
        run_op(op_jal, 64'd0, 64'd0, imm, pc, npc, 1'b1);
        run_op(op_jal, 64'd0, 64'd0, imm, pc, pc + FALLTHRU_STEP, 1'b1);
        npc = expected_npc(op_jalr, base, 64'd0, imm, pc);
        run_op(op_jalr, base, 64'd0, imm, pc, npc, 1'b1);
        run_op(op_jalr, base, 64'd0, imm, pc, pc + FALLTHRU_STEP, 1'b1);
        run_op(op_jalr, base, 64'd0, imm, pc, pc + FALLTHRU_STEP, 1'b0);
        run_op(op_auipc, 64'd0, 64'd0, imm, pc, rand_word(), 1'b1);
        run_op(op_auipc, 64'd0, 64'd0, 20'h12345, pc, rand_word(), 1'b1);
    endtask

    // A sits in writeback and B in stage one while the stall is high
    task automatic test_stall();
        logic [63:0] a0;
        logic [63:0] a1;
        logic [63:0] b0;
        logic [63:0] b1;
        int          cycles;
        a0 = rand_word();
        a1 = rand_word();
        b0 = rand_word();
        b1 = rand_word();
        @(posedge clk);
        #2;
        drive_op(op_add, a0, a1, 20'd0, 64'h400, 64'd0, 6'd1, 7'd10, 1'b1, 4'd2, 5'd0);
        @(posedge clk);
        #2;
        drive_op(op_xor, b0, b1, 20'd0, 64'h404, 64'd0, 6'd2, 7'd11, 1'b1, 4'd2, 5'd4);
        @(posedge clk);
        #2;
        i_vld = 1'b0;
        i_wb_stall = 1'b1;
        // new operands on the inputs must stay out of stage one
        i_src0 = rand_word();
        i_src1 = rand_word();
        i_prd_idx = 7'd12;
        repeat (4) begin
            @(negedge clk);
            check_val("o_fu_finished", 64'(o_fu_finished), 64'd1);
            check_val("o_wb_rob_idx", 64'(o_wb_rob_idx), 64'd1);
            check_val("o_wb_result", o_wb_result, a0 + a1);
            check_val("o_willwrite_vld", 64'(o_willwrite_vld), 64'd1);
            check_val("o_willwrite_prd", 64'(o_willwrite_prd), 64'd11);
            check_val("o_willwrite_data", o_willwrite_data, b0 ^ b1);
        end
        @(posedge clk);
        #2;
        i_wb_stall = 1'b0;
        cycles = 0;
        while (!(o_fu_finished && o_wb_rob_idx == 6'd2) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (o_fu_finished && o_wb_rob_idx == 6'd2) else begin
            $display("second op did not complete within %0d cycles of stall release",
                     WAIT_LIMIT);
            errors++;
        end
        check_val("o_wb_result", o_wb_result, b0 ^ b1);
        check_val("o_wb_prd_idx", 64'(o_wb_prd_idx), 64'd11);
    endtask

    initial begin
        seed = 32'h6b9025e2;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        // a mispredicting jal waits on the inputs, only reset keeps the valids low
        i_vld = 1'b1;
        i_op = op_jal;
        i_src0 = '0;
        i_src1 = '0;
        i_imm20 = '0;
        i_pc = '0;
        i_pred_npc = FALLTHRU_STEP;
        i_rob_idx = '0;
        i_prd_idx = '0;
        i_rd_wen = 1'b1;
        i_ftq_idx = '0;
        i_ftq_offset = '0;
        i_wb_stall = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        i_vld = 1'b0;
        test_reset();
        test_alu_ops();
        test_bypass();
        test_cond_branches();
        test_jumps();
        test_stall();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/exec_pkg.sv
hw/int_alu.sv
hw/branch_resolver.sv
hw/exec_ctrl.sv
hw/int_exec_unit.sv
sim/int_exec_unit_checker.sv
sim/int_exec_unit_tb.sv
